// ==== logic/mem_pkg.sv ====
package mem_pkg;

	// data and address width
	localparam int WORD_SIZE = 16;

	// words per cache line, one line per port-1 transfer
	localparam int LINE_WORDS = 4;
	localparam int LINE_SIZE = WORD_SIZE * LINE_WORDS;

	// controller states for both caches
	// st_write_wait is only reached by the data cache
	typedef enum logic [1:0] {
		st_idle,
		st_lookup,
		st_fill,
		st_write_wait
	} cache_state_e;

	// current owner of memory port 1
	typedef enum logic [1:0] {
		owner_none,
		owner_instr,
		owner_data
	} port_owner_e;

endpackage

// ==== logic/instr_cache.sv ====
module instr_cache #(
	parameter int NUM_LINES = 16
) (
	input  logic                           clk,
	input  logic                           i_reset,
	input  logic                           i_fetch_req,
	input  logic [mem_pkg::WORD_SIZE-1:0]  i_fetch_addr,
	input  logic [mem_pkg::LINE_SIZE-1:0]  i_fill_data,
	input  logic                           i_fill_done,
	output logic                           o_fetch_ready,
	output logic [mem_pkg::WORD_SIZE-1:0]  o_fetch_data,
	output logic                           o_fill_req,
	output logic [mem_pkg::WORD_SIZE-1:0]  o_fill_addr
);

	localparam int OFFSET_W = $clog2(mem_pkg::LINE_WORDS);
	localparam int INDEX_W = $clog2(NUM_LINES);
	localparam int TAG_W = mem_pkg::WORD_SIZE - INDEX_W - OFFSET_W;

	mem_pkg::cache_state_e state;

	logic [mem_pkg::WORD_SIZE-1:0] req_addr;
	logic [TAG_W-1:0] tags [NUM_LINES];
	logic [mem_pkg::LINE_SIZE-1:0] lines [NUM_LINES];
	logic [NUM_LINES-1:0] valid;

	logic [OFFSET_W-1:0] req_offset;
	logic [INDEX_W-1:0] req_index;
	logic [TAG_W-1:0] req_tag;
	logic hit;
	logic accept;

	assign req_offset = req_addr[OFFSET_W-1:0];
	assign req_index = req_addr[OFFSET_W +: INDEX_W];
	assign req_tag = req_addr[mem_pkg::WORD_SIZE-1 -: TAG_W];
	assign hit = valid[req_index] && (tags[req_index] == req_tag);

	// skip the ready cycle so a held request is not served twice
	assign accept = (state == mem_pkg::st_idle) && i_fetch_req && !o_fetch_ready;

	assign o_fill_req = (state == mem_pkg::st_fill);
	assign o_fill_addr = {req_addr[mem_pkg::WORD_SIZE-1:OFFSET_W], {OFFSET_W{1'b0}}};

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= mem_pkg::st_idle;
			valid <= '0;
			o_fetch_ready <= 1'b0;
		end else begin
			o_fetch_ready <= 1'b0;
			case (state)
				mem_pkg::st_idle: begin
					if (accept)
						state <= mem_pkg::st_lookup;
				end
				mem_pkg::st_lookup: begin
					if (hit) begin
						o_fetch_ready <= 1'b1;
						state <= mem_pkg::st_idle;
					end else begin
						state <= mem_pkg::st_fill;
					end
				end
				mem_pkg::st_fill: begin
					// reread the new line in lookup
					if (i_fill_done) begin
						valid[req_index] <= 1'b1;
						state <= mem_pkg::st_lookup;
					end
				end
				default: state <= mem_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			req_addr <= i_fetch_addr;
		if (state == mem_pkg::st_lookup && hit)
			o_fetch_data <= lines[req_index][req_offset*mem_pkg::WORD_SIZE +: mem_pkg::WORD_SIZE];
		if (state == mem_pkg::st_fill && i_fill_done) begin
			tags[req_index] <= req_tag;
			lines[req_index] <= i_fill_data;
		end
	end

	// ready only answers a request seen the cycle before
	assert property (@(posedge clk) disable iff (i_reset)
		o_fetch_ready |-> $past(i_fetch_req));

endmodule

// ==== logic/data_cache.sv ====
module data_cache #(
	parameter int NUM_LINES = 16
) (
	input  logic                           clk,
	input  logic                           i_reset,
	input  logic                           i_load_req,
	input  logic                           i_store_req,
	input  logic [mem_pkg::WORD_SIZE-1:0]  i_data_addr,
	input  logic [mem_pkg::WORD_SIZE-1:0]  i_store_data,
	input  logic [mem_pkg::LINE_SIZE-1:0]  i_fill_data,
	input  logic                           i_fill_done,
	input  logic                           i_store_hold,
	input  logic                           i_mem2_ack,
	output logic                           o_data_ready,
	output logic [mem_pkg::WORD_SIZE-1:0]  o_load_data,
	output logic                           o_fill_req,
	output logic [mem_pkg::WORD_SIZE-1:0]  o_fill_addr,
	output logic                           o_mem2_write,
	output logic [mem_pkg::WORD_SIZE-1:0]  o_mem2_addr,
	output logic [mem_pkg::WORD_SIZE-1:0]  o_mem2_wdata
);

	localparam int OFFSET_W = $clog2(mem_pkg::LINE_WORDS);
	localparam int INDEX_W = $clog2(NUM_LINES);
	localparam int TAG_W = mem_pkg::WORD_SIZE - INDEX_W - OFFSET_W;

	mem_pkg::cache_state_e state;

	logic [mem_pkg::WORD_SIZE-1:0] req_addr;
	logic [mem_pkg::WORD_SIZE-1:0] req_wdata;
	logic req_store;
	logic [TAG_W-1:0] tags [NUM_LINES];
	logic [mem_pkg::LINE_SIZE-1:0] lines [NUM_LINES];
	logic [NUM_LINES-1:0] valid;

	logic [OFFSET_W-1:0] req_offset;
	logic [INDEX_W-1:0] req_index;
	logic [TAG_W-1:0] req_tag;
	logic hit;
	logic accept;
	logic store_go;

	assign req_offset = req_addr[OFFSET_W-1:0];
	assign req_index = req_addr[OFFSET_W +: INDEX_W];
	assign req_tag = req_addr[mem_pkg::WORD_SIZE-1 -: TAG_W];
	assign hit = valid[req_index] && (tags[req_index] == req_tag);

	assign accept = (state == mem_pkg::st_idle) && (i_load_req || i_store_req) && !o_data_ready;

	// store leaves lookup only while the bus is not granted away
	assign store_go = (state == mem_pkg::st_lookup) && req_store && !i_store_hold;

	assign o_fill_req = (state == mem_pkg::st_fill);
	assign o_fill_addr = {req_addr[mem_pkg::WORD_SIZE-1:OFFSET_W], {OFFSET_W{1'b0}}};

	// write-through, single word on port 2
	assign o_mem2_write = (state == mem_pkg::st_write_wait);
	assign o_mem2_addr = req_addr;
	assign o_mem2_wdata = req_wdata;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= mem_pkg::st_idle;
			valid <= '0;
			o_data_ready <= 1'b0;
		end else begin
			o_data_ready <= 1'b0;
			case (state)
				mem_pkg::st_idle: begin
					if (accept)
						state <= mem_pkg::st_lookup;
				end
				mem_pkg::st_lookup: begin
					if (req_store) begin
						if (store_go)
							state <= mem_pkg::st_write_wait;
					end else if (hit) begin
						o_data_ready <= 1'b1;
						state <= mem_pkg::st_idle;
					end else begin
						state <= mem_pkg::st_fill;
					end
				end
				mem_pkg::st_fill: begin
					if (i_fill_done) begin
						valid[req_index] <= 1'b1;
						state <= mem_pkg::st_lookup;
					end
				end
				mem_pkg::st_write_wait: begin
					if (i_mem2_ack) begin
						o_data_ready <= 1'b1;
						state <= mem_pkg::st_idle;
					end
				end
				default: state <= mem_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr <= i_data_addr;
			req_wdata <= i_store_data;
			req_store <= i_store_req;
		end
		if (state == mem_pkg::st_lookup && !req_store && hit)
			o_load_data <= lines[req_index][req_offset*mem_pkg::WORD_SIZE +: mem_pkg::WORD_SIZE];
		if (state == mem_pkg::st_fill && i_fill_done) begin
			tags[req_index] <= req_tag;
			lines[req_index] <= i_fill_data;
		end
		// no allocate, patch only on a hit
		if (store_go && hit)
			lines[req_index][req_offset*mem_pkg::WORD_SIZE +: mem_pkg::WORD_SIZE] <= req_wdata;
	end

	assert property (@(posedge clk) disable iff (i_reset)
		!(i_load_req && i_store_req));

endmodule

// ==== logic/mem_port_arbiter.sv ====
module mem_port_arbiter (
	input  logic                           clk,
	input  logic                           i_reset,
	input  logic                           i_ifill_req,
	input  logic [mem_pkg::WORD_SIZE-1:0]  i_ifill_addr,
	input  logic                           i_dfill_req,
	input  logic [mem_pkg::WORD_SIZE-1:0]  i_dfill_addr,
	input  logic                           i_mem1_ready,
	input  logic                           i_mem2_write,
	input  logic                           i_bus_request,
	output logic                           o_mem1_read,
	output logic [mem_pkg::WORD_SIZE-1:0]  o_mem1_addr,
	output logic                           o_ifill_done,
	output logic                           o_dfill_done,
	output logic                           o_store_hold,
	output logic                           o_bus_grant
);

	mem_pkg::port_owner_e owner;
	logic grant_q;

	// instruction fills win a tie
	always_ff @(posedge clk) begin
		if (i_reset) begin
			owner <= mem_pkg::owner_none;
		end else begin
			case (owner)
				mem_pkg::owner_none: begin
					if (i_ifill_req)
						owner <= mem_pkg::owner_instr;
					else if (i_dfill_req)
						owner <= mem_pkg::owner_data;
				end
				default: begin
					if (i_mem1_ready)
						owner <= mem_pkg::owner_none;
				end
			endcase
		end
	end

	assign o_mem1_read = (owner != mem_pkg::owner_none);

	always_comb begin
		case (owner)
			mem_pkg::owner_instr: o_mem1_addr = i_ifill_addr;
			mem_pkg::owner_data:  o_mem1_addr = i_dfill_addr;
			default:              o_mem1_addr = '0;
		endcase
	end

	assign o_ifill_done = (owner == mem_pkg::owner_instr) && i_mem1_ready;
	assign o_dfill_done = (owner == mem_pkg::owner_data) && i_mem1_ready;

	// grant starts only with port 2 idle, then holds while requested
	assign o_bus_grant = i_bus_request && (grant_q || !i_mem2_write);
	assign o_store_hold = o_bus_grant;

	always_ff @(posedge clk) begin
		if (i_reset)
			grant_q <= 1'b0;
		else
			grant_q <= o_bus_grant;
	end

	// relies on the data cache honoring store_hold
	assert property (@(posedge clk) disable iff (i_reset)
		!(o_bus_grant && i_mem2_write));

endmodule

// ==== logic/cache_subsystem.sv ====
module cache_subsystem #(
	parameter int NUM_LINES = 16
) (
	input  logic                           clk,
	input  logic                           i_reset,

	// fetch side
	input  logic                           i_fetch_req,
	input  logic [mem_pkg::WORD_SIZE-1:0]  i_fetch_addr,
	output logic                           o_fetch_ready,
	output logic [mem_pkg::WORD_SIZE-1:0]  o_fetch_data,

	// load and store side
	input  logic                           i_load_req,
	input  logic                           i_store_req,
	input  logic [mem_pkg::WORD_SIZE-1:0]  i_data_addr,
	input  logic [mem_pkg::WORD_SIZE-1:0]  i_store_data,
	output logic                           o_data_ready,
	output logic [mem_pkg::WORD_SIZE-1:0]  o_load_data,

	// memory port 1, line fills
	output logic                           o_mem1_read,
	output logic [mem_pkg::WORD_SIZE-1:0]  o_mem1_addr,
	input  logic [mem_pkg::LINE_SIZE-1:0]  i_mem1_data,
	input  logic                           i_mem1_ready,

	// memory port 2, stores
	output logic                           o_mem2_write,
	output logic [mem_pkg::WORD_SIZE-1:0]  o_mem2_addr,
	output logic [mem_pkg::WORD_SIZE-1:0]  o_mem2_wdata,
	input  logic                           i_mem2_ack,

	// dma
	input  logic                           i_bus_request,
	output logic                           o_bus_grant
);

	logic ifill_req;
	logic [mem_pkg::WORD_SIZE-1:0] ifill_addr;
	logic ifill_done;
	logic dfill_req;
	logic [mem_pkg::WORD_SIZE-1:0] dfill_addr;
	logic dfill_done;
	logic store_hold;

	instr_cache #(
		.NUM_LINES(NUM_LINES)
	) u_instr_cache (
		.clk(clk),
		.i_reset(i_reset),
		.i_fetch_req(i_fetch_req),
		.i_fetch_addr(i_fetch_addr),
		.i_fill_data(i_mem1_data),
		.i_fill_done(ifill_done),
		.o_fetch_ready(o_fetch_ready),
		.o_fetch_data(o_fetch_data),
		.o_fill_req(ifill_req),
		.o_fill_addr(ifill_addr)
	);

	data_cache #(
		.NUM_LINES(NUM_LINES)
	) u_data_cache (
		.clk(clk),
		.i_reset(i_reset),
		.i_load_req(i_load_req),
		.i_store_req(i_store_req),
		.i_data_addr(i_data_addr),
		.i_store_data(i_store_data),
		.i_fill_data(i_mem1_data),
		.i_fill_done(dfill_done),
		.i_store_hold(store_hold),
		.i_mem2_ack(i_mem2_ack),
		.o_data_ready(o_data_ready),
		.o_load_data(o_load_data),
		.o_fill_req(dfill_req),
		.o_fill_addr(dfill_addr),
		.o_mem2_write(o_mem2_write),
		.o_mem2_addr(o_mem2_addr),
		.o_mem2_wdata(o_mem2_wdata)
	);

	// port 2 state feeds back into the dma grant
	mem_port_arbiter u_mem_port_arbiter (
		.clk(clk),
		.i_reset(i_reset),
		.i_ifill_req(ifill_req),
		.i_ifill_addr(ifill_addr),
		.i_dfill_req(dfill_req),
		.i_dfill_addr(dfill_addr),
		.i_mem1_ready(i_mem1_ready),
		.i_mem2_write(o_mem2_write),
		.i_bus_request(i_bus_request),
		.o_mem1_read(o_mem1_read),
		.o_mem1_addr(o_mem1_addr),
		.o_ifill_done(ifill_done),
		.o_dfill_done(dfill_done),
		.o_store_hold(store_hold),
		.o_bus_grant(o_bus_grant)
	);

endmodule

// ==== verif/mem_model.sv ====
module mem_model #(
	parameter logic [31:0] SEED = 32'h1
) (
	input  logic                           clk,
	input  logic                           i_reset,
	input  logic                           i_mem1_read,
	input  logic [mem_pkg::WORD_SIZE-1:0]  i_mem1_addr,
	output logic [mem_pkg::LINE_SIZE-1:0]  o_mem1_data,
	output logic                           o_mem1_ready,
	input  logic                           i_mem2_write,
	input  logic [mem_pkg::WORD_SIZE-1:0]  i_mem2_addr,
	input  logic [mem_pkg::WORD_SIZE-1:0]  i_mem2_wdata,
	output logic                           o_mem2_ack
);

	logic [mem_pkg::WORD_SIZE-1:0] words [2**mem_pkg::WORD_SIZE];
	logic [mem_pkg::WORD_SIZE-1:0] addr1;
	logic [mem_pkg::WORD_SIZE-1:0] addr2;
	logic [mem_pkg::WORD_SIZE-1:0] data2;
	logic [31:0] rng;
	logic busy1;
	logic busy2;
	int wait1;
	int wait2;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// 1 to 6 cycles
	function int latency();
		rng = xorshift(rng);
		return 1 + int'(rng % 32'd6);
	endfunction

	initial begin
		o_mem1_ready = 1'b0;
		o_mem1_data = '0;
		o_mem2_ack = 1'b0;
		for (int a = 0; a < 2**mem_pkg::WORD_SIZE; a++)
			words[a] = 16'(a) ^ 16'hA5A5;
	end

	always @(posedge clk) begin
		if (i_reset) begin
			rng = SEED;
			busy1 <= 1'b0;
			busy2 <= 1'b0;
			o_mem1_ready <= 1'b0;
			o_mem2_ack <= 1'b0;
		end else begin
			o_mem1_ready <= 1'b0;
			o_mem2_ack <= 1'b0;
			// request is still up on the edge that ends the pulse
			if (!busy1 && !o_mem1_ready && i_mem1_read) begin
				busy1 <= 1'b1;
				wait1 <= latency();
				addr1 <= i_mem1_addr;
			end else if (busy1 && wait1 > 1) begin
				wait1 <= wait1 - 1;
			end else if (busy1) begin
				busy1 <= 1'b0;
				o_mem1_ready <= 1'b1;
				o_mem1_data <= {words[addr1 + 16'd3], words[addr1 + 16'd2],
					words[addr1 + 16'd1], words[addr1]};
			end
			if (!busy2 && !o_mem2_ack && i_mem2_write) begin
				busy2 <= 1'b1;
				wait2 <= latency();
				addr2 <= i_mem2_addr;
				data2 <= i_mem2_wdata;
			end else if (busy2 && wait2 > 1) begin
				wait2 <= wait2 - 1;
			end else if (busy2) begin
				busy2 <= 1'b0;
				o_mem2_ack <= 1'b1;
				words[addr2] <= data2;
			end
		end
	end

endmodule

// ==== verif/cache_subsystem_tb.sv ====
module cache_subsystem_tb;

	localparam int NUM_LINES = 16;
	localparam int WORD_W = mem_pkg::WORD_SIZE;
	localparam int TIMEOUT = 300;
	localparam logic [31:0] SEED = 32'h55df6cd4;

	logic clk;
	logic i_reset;
	logic i_fetch_req;
	logic [WORD_W-1:0] i_fetch_addr;
	logic o_fetch_ready;
	logic [WORD_W-1:0] o_fetch_data;
	logic i_load_req;
	logic i_store_req;
	logic [WORD_W-1:0] i_data_addr;
	logic [WORD_W-1:0] i_store_data;
	logic o_data_ready;
	logic [WORD_W-1:0] o_load_data;
	logic o_mem1_read;
	logic [WORD_W-1:0] o_mem1_addr;
	logic [mem_pkg::LINE_SIZE-1:0] i_mem1_data;
	logic i_mem1_ready;
	logic o_mem2_write;
	logic [WORD_W-1:0] o_mem2_addr;
	logic [WORD_W-1:0] o_mem2_wdata;
	logic i_mem2_ack;
	logic i_bus_request;
	logic o_bus_grant;

	int errors = 0;
	int errors_before = 0;
	int tests_run = 0;
	logic [31:0] rng_state = SEED;

	// expected memory with every completed store applied
	logic [WORD_W-1:0] shadow [2**WORD_W];
	logic [WORD_W-1:0] exp_fetch;
	logic [WORD_W-1:0] exp_load;

	logic req_seen = 1'b0;
	logic expect_hit = 1'b0;
	logic data_is_load = 1'b0;
	logic race_on = 1'b0;
	logic [WORD_W-1:0] race_line = '0;
	logic read_prev = 1'b0;
	int read_starts = 0;
	int reads_at_race = 0;
	int ack_total = 0;
	int acks_at_issue = 0;

	assign exp_fetch = shadow[i_fetch_addr];
	assign exp_load = shadow[i_data_addr];

	cache_subsystem #(
		.NUM_LINES(NUM_LINES)
	) uut (
		.clk(clk), .i_reset(i_reset),
		.i_fetch_req(i_fetch_req), .i_fetch_addr(i_fetch_addr),
		.o_fetch_ready(o_fetch_ready), .o_fetch_data(o_fetch_data),
		.i_load_req(i_load_req), .i_store_req(i_store_req),
		.i_data_addr(i_data_addr), .i_store_data(i_store_data),
		.o_data_ready(o_data_ready), .o_load_data(o_load_data),
		.o_mem1_read(o_mem1_read), .o_mem1_addr(o_mem1_addr),
		.i_mem1_data(i_mem1_data), .i_mem1_ready(i_mem1_ready),
		.o_mem2_write(o_mem2_write), .o_mem2_addr(o_mem2_addr),
		.o_mem2_wdata(o_mem2_wdata), .i_mem2_ack(i_mem2_ack),
		.i_bus_request(i_bus_request), .o_bus_grant(o_bus_grant)
	);

	mem_model #(
		.SEED(SEED)
	) u_mem (
		.clk(clk), .i_reset(i_reset),
		.i_mem1_read(o_mem1_read), .i_mem1_addr(o_mem1_addr),
		.o_mem1_data(i_mem1_data), .o_mem1_ready(i_mem1_ready),
		.i_mem2_write(o_mem2_write), .i_mem2_addr(o_mem2_addr),
		.i_mem2_wdata(o_mem2_wdata), .o_mem2_ack(i_mem2_ack)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	always @(posedge clk) begin
		read_prev <= o_mem1_read;
		if (o_mem1_read && !read_prev)
			read_starts <= read_starts + 1;
		if (o_mem2_write && i_mem2_ack)
			ack_total <= ack_total + 1;
	end

	// quiet until the first request
	assert property (@(posedge clk) disable iff (i_reset) !req_seen |->
		!(o_fetch_ready || o_data_ready || o_mem1_read || o_mem2_write || o_bus_grant))
	else begin
		errors++;
		$display("** Error: control outputs = 0x%h before any request, expected 0x00",
			$sampled({o_fetch_ready, o_data_ready, o_mem1_read, o_mem2_write, o_bus_grant}));
	end

	assert property (@(posedge clk) disable iff (i_reset)
		o_fetch_ready |-> o_fetch_data == exp_fetch)
	else begin
		errors++;
		$display("** Error: o_fetch_data = 0x%h, expected 0x%h",
			$sampled(o_fetch_data), $sampled(exp_fetch));
	end

	assert property (@(posedge clk) disable iff (i_reset)
		o_data_ready && data_is_load |-> o_load_data == exp_load)
	else begin
		errors++;
		$display("** Error: o_load_data = 0x%h, expected 0x%h",
			$sampled(o_load_data), $sampled(exp_load));
	end

	assert property (@(posedge clk) disable iff (i_reset) expect_hit |-> !o_mem1_read)
	else begin
		errors++;
		$display("** Error: o_mem1_read = 0x1 on a repeated line access, expected 0x0");
	end

	assert property (@(posedge clk) disable iff (i_reset)
		o_mem2_write |-> o_mem2_addr == i_data_addr && o_mem2_wdata == i_store_data)
	else begin
		errors++;
		$display("** Error: o_mem2_addr/o_mem2_wdata = 0x%h/0x%h, expected 0x%h/0x%h",
			$sampled(o_mem2_addr), $sampled(o_mem2_wdata),
			$sampled(i_data_addr), $sampled(i_store_data));
	end

	assert property (@(posedge clk) disable iff (i_reset)
		o_data_ready && !data_is_load |-> ack_total - acks_at_issue == 1)
	else begin
		errors++;
		$display("** Error: port-2 writes for one store = 0x%h, expected 0x1",
			$sampled(ack_total - acks_at_issue));
	end

	// first fill after simultaneous misses goes to the instruction line
	assert property (@(posedge clk) disable iff (i_reset)
		race_on && $rose(o_mem1_read) && read_starts == reads_at_race |->
		o_mem1_addr == race_line)
	else begin
		errors++;
		$display("** Error: o_mem1_addr = 0x%h, expected 0x%h",
			$sampled(o_mem1_addr), $sampled(race_line));
	end

	assert property (@(posedge clk) disable iff (i_reset) !(o_bus_grant && o_mem2_write))
	else begin
		errors++;
		$display("** Error: o_bus_grant = 0x1 while o_mem2_write = 0x1, expected 0x0");
	end

	assert property (@(posedge clk) disable iff (i_reset)
		$rose(o_mem2_write) |-> !$past(i_bus_request))
	else begin
		errors++;
		$display("port-2 write started while the DMA request was still up");
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function logic [WORD_W-1:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state[WORD_W-1:0];
	endfunction

	task automatic give_up(input string why);
		errors++;
		$display("timeout: %s", why);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		$display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
		errors_before = errors;
	endtask

	// waits on the falling edge, then drops the request
	task automatic wait_ready(input logic is_fetch);
		int n;
		n = 0;
		while (!(is_fetch ? o_fetch_ready : o_data_ready) && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (n >= TIMEOUT) begin
			give_up(is_fetch ? "o_fetch_ready never came" : "o_data_ready never came");
		end else begin
			i_fetch_req = is_fetch ? 1'b0 : i_fetch_req;
			i_load_req = is_fetch ? i_load_req : 1'b0;
			i_store_req = is_fetch ? i_store_req : 1'b0;
			expect_hit = 1'b0;
		end
	endtask

	task automatic fetch(input logic [WORD_W-1:0] addr, input logic hit_expected);
		@(negedge clk);
		i_fetch_addr = addr;
		i_fetch_req = 1'b1;
		req_seen = 1'b1;
		expect_hit = hit_expected;
		wait_ready(1'b1);
	endtask

	task automatic load(input logic [WORD_W-1:0] addr, input logic hit_expected);
		@(negedge clk);
		i_data_addr = addr;
		i_load_req = 1'b1;
		data_is_load = 1'b1;
		req_seen = 1'b1;
		expect_hit = hit_expected;
		wait_ready(1'b0);
	endtask

	task automatic issue_store(input logic [WORD_W-1:0] addr, input logic [WORD_W-1:0] data);
		@(negedge clk);
		i_data_addr = addr;
		i_store_data = data;
		i_store_req = 1'b1;
		data_is_load = 1'b0;
		acks_at_issue = ack_total;
		req_seen = 1'b1;
	endtask

	task automatic store(input logic [WORD_W-1:0] addr, input logic [WORD_W-1:0] data);
		issue_store(addr, data);
		wait_ready(1'b0);
		shadow[addr] = data;
	endtask

	task automatic fetch_and_load(input logic [WORD_W-1:0] iaddr,
		input logic [WORD_W-1:0] daddr);
		int n;
		logic got_i;
		logic got_d;
		@(negedge clk);
		i_fetch_addr = iaddr;
		i_data_addr = daddr;
		i_fetch_req = 1'b1;
		i_load_req = 1'b1;
		data_is_load = 1'b1;
		race_line = {iaddr[WORD_W-1:2], 2'b00};
		reads_at_race = read_starts;
		race_on = 1'b1;
		got_i = 1'b0;
		got_d = 1'b0;
		n = 0;
		while (!(got_i && got_d) && n < TIMEOUT) begin
			@(negedge clk);
			n++;
			if (o_fetch_ready) begin
				got_i = 1'b1;
				i_fetch_req = 1'b0;
			end
			if (o_data_ready) begin
				got_d = 1'b1;
				i_load_req = 1'b0;
			end
		end
		race_on = 1'b0;
		if (!(got_i && got_d))
			give_up("simultaneous instruction and data misses did not both finish");
	endtask

	task automatic wait_grant();
		int n;
		n = 0;
		while (!o_bus_grant && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!o_bus_grant)
			give_up("o_bus_grant never came for the DMA request");
	endtask

	initial begin
		logic [WORD_W-1:0] addr;
		logic [WORD_W-1:0] data;
		i_reset = 1'b1;
		i_fetch_req = 1'b0;
		i_fetch_addr = '0;
		i_load_req = 1'b0;
		i_store_req = 1'b0;
		i_data_addr = '0;
		i_store_data = '0;
		i_bus_request = 1'b0;
		for (int a = 0; a < 2**WORD_W; a++)
			shadow[a] = 16'(a) ^ 16'hA5A5;
		repeat (4) @(negedge clk);
		i_reset = 1'b0;

		repeat (6) @(negedge clk);
		finish_test("reset state");

		// fetches below 0x4000, data in 0x4000-0x7fff so stores never alias code
		for (int i = 0; i < 12; i++) begin
			fetch(next_rand() & 16'h3FFF, 1'b0);
			load(16'h4000 | (next_rand() & 16'h3FFF), 1'b0);
		end
		finish_test("fetch and load data");

		for (int i = 0; i < 4; i++) begin
			addr = next_rand() & 16'h3FFF;
			fetch(addr, 1'b0);
			fetch(addr ^ 16'h1, 1'b1);
			addr = 16'h4000 | (next_rand() & 16'h3FFF);
			load(addr, 1'b0);
			load(addr ^ 16'h2, 1'b1);
		end
		finish_test("repeated line access");

		for (int i = 0; i < 4; i++) begin
			addr = 16'h4000 | (next_rand() & 16'h3FFF);
			data = next_rand();
			load(addr, 1'b0);
			store(addr, data);
			load(addr, 1'b1);
			addr = 16'h4000 | (next_rand() & 16'h3FFF);
			store(addr, next_rand());
			load(addr, 1'b0);
		end
		finish_test("store write-through");

		// fresh tags so both sides miss
		for (int k = 0; k < 4; k++)
			fetch_and_load(16'h8000 + 16'(k * 64) + (next_rand() & 16'h3),
				16'h9000 + 16'(k * 64) + (next_rand() & 16'h3));
		finish_test("simultaneous misses");

		for (int i = 0; i < 2; i++) begin
			@(negedge clk);
			i_bus_request = 1'b1;
			req_seen = 1'b1;
			wait_grant();
			addr = 16'h4000 | (next_rand() & 16'h3FFF);
			data = next_rand();
			issue_store(addr, data);
			repeat (8) @(negedge clk);
			i_bus_request = 1'b0;
			wait_ready(1'b0);
			shadow[addr] = data;
			load(addr, 1'b0);
		end
		finish_test("dma grant");

		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
logic/mem_pkg.sv
logic/instr_cache.sv
logic/data_cache.sv
logic/mem_port_arbiter.sv
logic/cache_subsystem.sv
verif/mem_model.sv
verif/cache_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: cache_subsystem

sources:
  - files:
      - logic/mem_pkg.sv
      - logic/instr_cache.sv
      - logic/data_cache.sv
      - logic/mem_port_arbiter.sv
      - logic/cache_subsystem.sv
  - target: test
    files:
      - verif/mem_model.sv
      - verif/cache_subsystem_tb.sv
